// ==== source/board_pkg.sv ====
`default_nettype none

package board_pkg;

	// One player's joystick byte, bit 7 down to bit 0
	typedef struct packed {
		logic [1:0] unused;
		logic fire_b;         // Start
		logic fire_a;         // Coin
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// Menu status word from the board
	typedef struct packed {
		logic [20:0] spare_hi;   // Bits 31 to 11
		logic [3:0] playtime;    // 0 to 10, larger values clamp
		logic coinage;           // 0 one credit per coin, 1 two credits
		logic [4:0] spare_lo;    // Bits 5 to 1
		logic soft_reset;
	} status_t;

	localparam int PLAYTIME_MAX = 10;

	localparam int COIN_PULSE_CYCLES = 16;
	localparam int COIN_CNT_W = $clog2(COIN_PULSE_CYCLES);
	typedef logic [COIN_CNT_W-1:0] coin_cnt_t;

endpackage

`default_nettype wire

// ==== source/race_pkg.sv ====
`default_nettype none

package race_pkg;

	// Shrunk raster, counts start at zero
	localparam int H_TOTAL = 64;
	localparam int H_ACTIVE = 48;
	localparam int V_TOTAL = 40;
	localparam int V_ACTIVE = 32;
	localparam int HS_START = 52;
	localparam int HS_LEN = 4;
	localparam int VS_START = 35;
	localparam int VS_LEN = 2;

	typedef logic [5:0] hpos_t;
	typedef logic [5:0] vpos_t;

	typedef struct packed {
		hpos_t hpos;
		vpos_t vpos;
		logic hsync;
		logic vsync;
		logic blank;
	} raster_t;

	localparam int NUM_LANES = 2;

	typedef struct packed {
		logic up;
		logic down;
	} lane_cmd_t;

	localparam int LANE_COL [NUM_LANES] = '{12, 34}; // Left edge of each rocket
	localparam int ROCKET_W = 2;
	localparam int ROCKET_H = 3;
	localparam int LANE_BOTTOM = 28; // Home row, top of rocket

	typedef logic [3:0] score_t;
	localparam int SCORE_MAX = 15;
	localparam int SCORE_ROW = 30;

	typedef struct packed {
		logic rocket;
		logic score;
	} lane_pix_t;

	typedef logic [3:0] credits_t;
	localparam int CREDITS_MAX = 9;

	// Game length is GAME_BASE_FRAMES + FRAMES_PER_STEP * playtime
	localparam int FRAMES_PER_STEP = 4;
	localparam int GAME_BASE_FRAMES = 8;
	typedef logic [5:0] frames_t;

	typedef logic [3:0] intensity_t;
	localparam intensity_t INT_ROCKET = 4'd15;
	localparam intensity_t INT_SCORE = 4'd11;
	localparam intensity_t INT_BLACK = 4'd0;

endpackage

`default_nettype wire

// ==== source/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
	input wire logic clk_sys,
	input wire logic reset,
	output race_pkg::raster_t raster,
	output logic frame_tick
);
	import race_pkg::*;

	hpos_t hcnt;
	vpos_t vcnt;
	logic hs_next;
	logic vs_next;
	logic blank_next;

	// Free running position counters
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == hpos_t'(H_TOTAL - 1)) begin
			hcnt <= '0;
			if (vcnt == vpos_t'(V_TOTAL - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	always_comb begin
		hs_next = int'(hcnt) >= HS_START && int'(hcnt) < HS_START + HS_LEN;
		vs_next = int'(vcnt) >= VS_START && int'(vcnt) < VS_START + VS_LEN;
		blank_next = int'(hcnt) >= H_ACTIVE || int'(vcnt) >= V_ACTIVE;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			raster <= '{hpos: '0, vpos: '0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
			frame_tick <= 1'b0;
		end else begin
			raster.hpos <= hcnt;
			raster.vpos <= vcnt;
			raster.hsync <= hs_next;
			raster.vsync <= vs_next;
			raster.blank <= blank_next;
			frame_tick <= hcnt == '0 && vcnt == '0; // Same cycle as position 0,0
		end
	end

endmodule

`default_nettype wire

// ==== source/control_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
	input wire logic clk_sys,
	input wire logic reset,
	input wire board_pkg::joy_t joy [race_pkg::NUM_LANES],
	input wire board_pkg::status_t status,
	input wire logic credit_light_n,
	output race_pkg::lane_cmd_t lane_cmd [race_pkg::NUM_LANES],
	output logic start,
	output logic coin_pulse,
	output logic coinage,
	output logic [3:0] playtime,
	output logic core_reset
);
	import board_pkg::*;
	import race_pkg::*;

	joy_t joy_q [NUM_LANES];
	logic [3:0] playtime_q;
	logic fire_a;
	logic fire_a_q;
	coin_cnt_t coin_cnt;

	always_ff @(posedge clk_sys) begin
		core_reset <= reset | status.soft_reset;
	end

	// Board inputs sampled once
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_q <= '{default: '0};
			coinage <= 1'b0;
			playtime_q <= '0;
		end else begin
			joy_q <= joy;
			coinage <= status.coinage;
			playtime_q <= status.playtime;
		end
	end

	always_comb begin
		fire_a = 1'b0;
		start = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			fire_a = fire_a | joy_q[i].fire_a; // Either player inserts a coin
			start = start | joy_q[i].fire_b;
			lane_cmd[i].up = joy_q[i].up;
			lane_cmd[i].down = joy_q[i].down;
		end
	end

	assign playtime = (playtime_q > 4'(PLAYTIME_MAX)) ? 4'(PLAYTIME_MAX) : playtime_q;

	// Coin edge stretched to a fixed pulse, taken only with no credit left
	always_ff @(posedge clk_sys) begin
		if (reset || core_reset) begin
			fire_a_q <= 1'b0;
			coin_pulse <= 1'b0;
			coin_cnt <= '0;
		end else begin
			fire_a_q <= fire_a;
			if (coin_pulse) begin
				if (coin_cnt == coin_cnt_t'(COIN_PULSE_CYCLES - 1))
					coin_pulse <= 1'b0;
				coin_cnt <= coin_cnt + 1'b1;
			end else if (fire_a && !fire_a_q && credit_light_n) begin
				coin_pulse <= 1'b1;
				coin_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/credit_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_keeper (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic coin_pulse,
	input wire logic start,
	input wire logic coinage,
	input wire logic [3:0] playtime,
	input wire logic frame_tick,
	output logic game_active,
	output logic credit_light_n
);
	import race_pkg::*;

	credits_t credits;
	credits_t credits_next;
	frames_t frames_left;
	logic coin_pulse_q;
	logic coin_rise;
	logic game_start;

	assign coin_rise = coin_pulse & ~coin_pulse_q;
	assign game_start = start && !game_active && credits != '0;

	// Coinage first, then the start fee
	always_comb begin
		int total;
		total = int'(credits);
		if (coin_rise)
			total = total + (coinage ? 2 : 1);
		if (total > CREDITS_MAX)
			total = CREDITS_MAX;
		if (game_start)
			total = total - 1;
		credits_next = credits_t'(total);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			coin_pulse_q <= 1'b0;
			credits <= '0;
			game_active <= 1'b0;
			frames_left <= '0;
		end else begin
			coin_pulse_q <= coin_pulse;
			credits <= credits_next;
			if (game_start) begin
				game_active <= 1'b1;
				frames_left <= frames_t'(GAME_BASE_FRAMES + FRAMES_PER_STEP * int'(playtime));
			end else if (game_active && frame_tick) begin
				frames_left <= frames_left - 1'b1;
				if (frames_left == frames_t'(1))
					game_active <= 1'b0; // Last frame of the game
			end
		end
	end

	assign credit_light_n = credits == '0;

endmodule

`default_nettype wire

// ==== source/rocket_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module rocket_lane #(
	parameter int LANE = 0
) (
	input wire logic clk_sys,
	input wire logic reset,
	input wire race_pkg::lane_cmd_t cmd,
	input wire logic game_active,
	input wire logic frame_tick,
	input wire race_pkg::raster_t raster,
	output race_pkg::lane_pix_t pix
);
	import race_pkg::*;

	localparam int COL = LANE_COL[LANE];

	vpos_t row; // Top row of the rocket
	score_t score;
	logic on_rocket;
	logic on_score;

	// Moves once per frame while a game runs
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			row <= vpos_t'(LANE_BOTTOM);
			score <= '0;
		end else if (frame_tick && game_active) begin
			if (cmd.up) begin
				if (row == vpos_t'(1)) begin
					row <= vpos_t'(LANE_BOTTOM); // Reached the top, back home
					if (score != score_t'(SCORE_MAX))
						score <= score + 1'b1;
				end else begin
					row <= row - 1'b1;
				end
			end else if (cmd.down && int'(row) < LANE_BOTTOM) begin
				row <= row + 1'b1;
			end
		end
	end

	always_comb begin
		int h;
		int v;
		h = int'(raster.hpos);
		v = int'(raster.vpos);
		on_rocket = h >= COL && h < COL + ROCKET_W && v >= int'(row) && v < int'(row) + ROCKET_H;
		on_score = v == SCORE_ROW && h >= COL && h < COL + 2 * int'(score); // Two pixels a point
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pix <= '0;
		end else begin
			pix.rocket <= on_rocket;
			pix.score <= on_score;
		end
	end

endmodule

`default_nettype wire

// ==== source/video_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_mixer (
	input wire logic clk_sys,
	input wire logic reset,
	input wire race_pkg::raster_t raster,
	input wire race_pkg::lane_pix_t pix [race_pkg::NUM_LANES],
	output race_pkg::intensity_t video,
	output logic hsync,
	output logic vsync,
	output logic blank
);
	import race_pkg::*;

	logic hsync_q;
	logic vsync_q;
	logic blank_q;
	logic any_rocket;
	logic any_score;

	always_comb begin
		any_rocket = 1'b0;
		any_score = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			any_rocket = any_rocket | pix[i].rocket;
			any_score = any_score | pix[i].score;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			blank_q <= 1'b1;
			hsync <= 1'b0;
			vsync <= 1'b0;
			blank <= 1'b1;
			video <= INT_BLACK;
		end else begin
			hsync_q <= raster.hsync; // Matches the lane flag delay
			vsync_q <= raster.vsync;
			blank_q <= raster.blank;
			hsync <= hsync_q;
			vsync <= vsync_q;
			blank <= blank_q;
			if (blank_q)
				video <= INT_BLACK;
			else if (any_rocket)
				video <= INT_ROCKET; // Rocket drawn over the score bar
			else if (any_score)
				video <= INT_SCORE;
			else
				video <= INT_BLACK;
		end
	end

endmodule

`default_nettype wire

// ==== source/space_race_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module space_race_board (
	input wire logic clk_sys,
	input wire logic reset,
	input wire board_pkg::joy_t joy [race_pkg::NUM_LANES],
	input wire board_pkg::status_t status,
	output wire race_pkg::intensity_t video,
	output wire logic hsync,
	output wire logic vsync,
	output wire logic blank,
	output wire logic credit_light_n
);
	import race_pkg::*;

	wire logic core_reset;
	wire lane_cmd_t lane_cmd [NUM_LANES];
	wire logic start;
	wire logic coin_pulse;
	wire logic coinage;
	wire logic [3:0] playtime;
	wire logic game_active;
	wire raster_t raster;
	wire logic frame_tick;
	wire lane_pix_t lane_pix [NUM_LANES];

	control_decoder decoder_i (
		.clk_sys(clk_sys),
		.reset(reset), // Board reset, the rest of the core runs on core_reset
		.joy(joy),
		.status(status),
		.credit_light_n(credit_light_n),
		.lane_cmd(lane_cmd),
		.start(start),
		.coin_pulse(coin_pulse),
		.coinage(coinage),
		.playtime(playtime),
		.core_reset(core_reset)
	);

	credit_keeper credit_i (
		.clk_sys(clk_sys),
		.reset(core_reset),
		.coin_pulse(coin_pulse),
		.start(start),
		.coinage(coinage),
		.playtime(playtime),
		.frame_tick(frame_tick),
		.game_active(game_active),
		.credit_light_n(credit_light_n)
	);

	raster_timing timing_i (
		.clk_sys(clk_sys),
		.reset(core_reset),
		.raster(raster),
		.frame_tick(frame_tick)
	);

	// One lane per player
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		rocket_lane #(.LANE(i)) lane_i (
			.clk_sys(clk_sys),
			.reset(core_reset),
			.cmd(lane_cmd[i]),
			.game_active(game_active),
			.frame_tick(frame_tick),
			.raster(raster),
			.pix(lane_pix[i])
		);
	end

	video_mixer mixer_i (
		.clk_sys(clk_sys),
		.reset(core_reset),
		.raster(raster),
		.pix(lane_pix),
		.video(video),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_space_race_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_space_race_board;
	import board_pkg::*;
	import race_pkg::*;

	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int GAME_SHORT = GAME_BASE_FRAMES + FRAMES_PER_STEP * 3;
	localparam int GAME_LONG = GAME_BASE_FRAMES + FRAMES_PER_STEP * PLAYTIME_MAX;
	localparam int TEST_FRAMES = 2 + GAME_SHORT + GAME_LONG + 6;
	localparam longint TIMEOUT_NS = longint'(TEST_FRAMES + 4) * FRAME_CYCLES * 10;

	// What the board sees on its video connector
	typedef struct packed {
		intensity_t video;
		logic hsync;
		logic vsync;
		logic blank;
	} screen_t;

	localparam screen_t SCREEN_RESET = '{video: INT_BLACK, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

	logic clk_sys;
	logic reset;
	joy_t joy [NUM_LANES];
	status_t status;
	intensity_t video;
	logic hsync;
	logic vsync;
	logic blank;
	logic credit_light_n;

	int errors;
	int seed;
	logic check_en;

	// Game model state as it stands after each rising edge
	logic m_core_reset = 1'b1;
	joy_t m_joy [NUM_LANES];
	int m_coinage;
	int m_playtime;
	logic m_fire_q;
	int m_coin_left; // Cycles of coin pulse still to run
	logic m_pulse_q;
	int m_credits;
	logic m_active;
	int m_frames;
	int m_hc;
	int m_vc;
	int m_h;
	int m_v;
	logic m_hs;
	logic m_vs;
	logic m_blank;
	logic m_tick;
	int m_row [NUM_LANES];
	int m_score [NUM_LANES];
	screen_t exp_q [3]; // Index 2 lines up with the DUT outputs

	space_race_board dut_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.joy(joy),
		.status(status),
		.video(video),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank),
		.credit_light_n(credit_light_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic intensity_t expected_video(input int h, input int v, input logic blanked,
			input int rows [NUM_LANES], input int scores [NUM_LANES]);
		logic rocket;
		logic bar;
		rocket = 1'b0;
		bar = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (h >= LANE_COL[i] && h < LANE_COL[i] + ROCKET_W
					&& v >= rows[i] && v < rows[i] + ROCKET_H)
				rocket = 1'b1;
			if (v == SCORE_ROW && h >= LANE_COL[i] && h < LANE_COL[i] + 2 * scores[i])
				bar = 1'b1;
		end
		if (blanked)
			return INT_BLACK;
		if (rocket)
			return INT_ROCKET; // Drawn over the bar
		if (bar)
			return INT_SCORE;
		return INT_BLACK;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	always @(posedge clk_sys) begin : model_step
		logic core_rst;
		logic light_n;
		logic start_in;
		logic fire_in;
		logic rise;
		logic game_start;
		int next_row;
		core_rst = m_core_reset;
		light_n = m_credits == 0;
		start_in = 1'b0;
		fire_in = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			start_in = start_in | m_joy[i].fire_b;
			fire_in = fire_in | m_joy[i].fire_a;
		end
		exp_q[2] = exp_q[1];
		exp_q[1] = exp_q[0];

		// Rockets move on the frame tick of a running game
		if (core_rst) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				m_row[i] = LANE_BOTTOM;
				m_score[i] = 0;
			end
		end else if (m_tick && m_active) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				if (m_joy[i].up) begin
					next_row = m_row[i] - 1;
					if (next_row == 0) begin // Top reached
						m_row[i] = LANE_BOTTOM;
						m_score[i] = (m_score[i] < SCORE_MAX) ? m_score[i] + 1 : SCORE_MAX;
					end else begin
						m_row[i] = next_row;
					end
				end else if (m_joy[i].down && m_row[i] < LANE_BOTTOM) begin
					m_row[i] = m_row[i] + 1;
				end
			end
		end

		// Credits and game countdown
		if (core_rst) begin
			m_pulse_q = 1'b0;
			m_credits = 0;
			m_active = 1'b0;
			m_frames = 0;
		end else begin
			rise = m_coin_left > 0 && !m_pulse_q;
			m_pulse_q = m_coin_left > 0;
			game_start = start_in && !m_active && m_credits != 0;
			if (rise)
				m_credits = m_credits + m_coinage + 1;
			if (m_credits > CREDITS_MAX)
				m_credits = CREDITS_MAX;
			if (game_start) begin
				m_credits = m_credits - 1;
				m_active = 1'b1;
				m_frames = GAME_BASE_FRAMES + FRAMES_PER_STEP * m_playtime;
			end else if (m_active && m_tick) begin
				if (m_frames == 1)
					m_active = 1'b0;
				m_frames = m_frames - 1;
			end
		end

		// Coin press stretched only while no credit is left
		if (reset || core_rst) begin
			m_fire_q = 1'b0;
			m_coin_left = 0;
		end else begin
			if (m_coin_left > 0)
				m_coin_left = m_coin_left - 1;
			else if (fire_in && !m_fire_q && light_n)
				m_coin_left = COIN_PULSE_CYCLES;
			m_fire_q = fire_in;
		end

		if (core_rst) begin
			m_hc = 0;
			m_vc = 0;
			m_h = 0;
			m_v = 0;
			m_hs = 1'b0;
			m_vs = 1'b0;
			m_blank = 1'b1;
			m_tick = 1'b0;
		end else begin
			m_h = m_hc;
			m_v = m_vc;
			m_hs = m_hc >= HS_START && m_hc < HS_START + HS_LEN;
			m_vs = m_vc >= VS_START && m_vc < VS_START + VS_LEN;
			m_blank = m_hc >= H_ACTIVE || m_vc >= V_ACTIVE;
			m_tick = m_hc == 0 && m_vc == 0;
			m_hc = m_hc + 1;
			if (m_hc == H_TOTAL) begin
				m_hc = 0;
				m_vc = (m_vc + 1) % V_TOTAL;
			end
		end

		if (reset) begin
			m_joy = '{default: '0};
			m_coinage = 0;
			m_playtime = 0;
		end else begin
			m_joy = joy;
			m_coinage = int'(status.coinage);
			m_playtime = (int'(status.playtime) > PLAYTIME_MAX) ? PLAYTIME_MAX
				: int'(status.playtime);
		end
		m_core_reset = reset || status.soft_reset;

		exp_q[0] = '{video: expected_video(m_h, m_v, m_blank, m_row, m_score),
			hsync: m_hs, vsync: m_vs, blank: m_blank};
		if (core_rst) begin
			exp_q[1] = SCREEN_RESET;
			exp_q[2] = SCREEN_RESET;
		end
	end

	// Outputs compared halfway through the cycle
	always @(negedge clk_sys) begin
		if (check_en) begin
			check_value("video", exp_q[2].video, video);
			check_value("hsync", exp_q[2].hsync, hsync);
			check_value("vsync", exp_q[2].vsync, vsync);
			check_value("blank", exp_q[2].blank, blank);
			check_value("credit_light_n", m_credits == 0, credit_light_n);
			check_value("game_active", m_active, dut_i.game_active);
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic press_coin(input int player);
		joy[player].fire_a = 1'b1;
		wait_cycles(4);
		joy[player].fire_a = 1'b0;
		wait_cycles(COIN_PULSE_CYCLES + 8); // Pulse plus credit update
	endtask

	// Starts a game and counts its frames until game_active drops
	task automatic play_game(input int expected_frames, input logic wander);
		int frames;
		logic [31:0] rnd;
		frames = 0;
		joy[0].fire_b = 1'b1;
		wait_cycles(2);
		joy[0].fire_b = 1'b0;
		if (!dut_i.game_active) begin
			errors++;
			$display("Game did not start after the start press at %0t ns", $time);
		end
		while (dut_i.game_active) begin
			if (dut_i.frame_tick) begin
				frames++;
				if (wander) begin
					rnd = $random(seed);
					joy[1].up = rnd[0];
					joy[1].down = rnd[1];
				end
			end
			wait_cycles(1);
		end
		check_value("game frames", expected_frames, frames);
	endtask

	initial begin
		errors = 0;
		seed = 82;
		check_en = 1'b0;
		reset = 1'b1;
		joy = '{default: '0};
		status = '0;
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		wait_cycles(4);
		check_en = 1'b1;

		wait_cycles(2 * FRAME_CYCLES); // Idle raster with the rockets at home

		press_coin(0);
		check_value("credits", 1, dut_i.credit_i.credits);
		check_value("credit_light_n", 0, credit_light_n);
		press_coin(1); // Ignored while a credit is left
		check_value("credits", 1, dut_i.credit_i.credits);

		status.playtime = 4'd3;
		joy[0].up = 1'b1;
		wait_cycles(4);
		play_game(GAME_SHORT, 1'b1);
		joy[0].up = 1'b0;
		joy[1].up = 1'b0;
		joy[1].down = 1'b0;
		check_value("credit_light_n", 1, credit_light_n);

		// Two credits per coin and a playtime over the limit
		status.coinage = 1'b1;
		status.playtime = 4'd13;
		wait_cycles(4);
		press_coin(0);
		check_value("credits", 2, dut_i.credit_i.credits);
		joy[0].down = 1'b1;
		joy[1].up = 1'b1;
		wait_cycles(4);
		play_game(GAME_LONG, 1'b0);
		check_value("credits", 1, dut_i.credit_i.credits);
		joy[0].down = 1'b0;
		joy[1].up = 1'b0;

		wait_cycles(FRAME_CYCLES / 2);
		status.soft_reset = 1'b1;
		wait_cycles(3);
		status.soft_reset = 1'b0;
		wait_cycles(4);
		check_value("credits", 0, dut_i.credit_i.credits);
		check_value("credit_light_n", 1, credit_light_n);
		wait_cycles(2 * FRAME_CYCLES); // Rockets back home and no score bars

		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout, the run did not finish within %0t ns", $time);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/board_pkg.sv
source/race_pkg.sv
source/raster_timing.sv
source/control_decoder.sv
source/credit_keeper.sv
source/rocket_lane.sv
source/video_mixer.sv
source/space_race_board.sv
testbench/tb_space_race_board.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the space race board testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_space_race_board \
	-f sim.f \
	-Mdir obj_dir \
	-o tb_space_race_board

./obj_dir/tb_space_race_board | tee "$LOG"

if grep -qF 'All tests passed!' "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
